/* Makefile */
# Verilator build, run, lint and clean for the APB FIFO display demonstrator

VERILATOR  ?= verilator
TOP        ?= tb_fifo_display
RTL_TOP    ?= fifo_display_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --timing -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall
PASS_TEXT  ?= Everything OK

RTL_SRCS   ?= fifo_pkg.sv display_pkg.sv apb_fifo_regs.sv ff_fifo.sv \
              seg_display_scan.sv fifo_display_top.sv

SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

# pass only when the pass line shows up in the simulation output
run: build
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* apb_fifo_regs.sv */
// APB slave with one wait state that maps data and status registers onto FIFO push and pop
`timescale 1ns/1ps
`default_nettype none

module apb_fifo_regs
  import fifo_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  input  apb_req_t    apb_req,
  output apb_rsp_t    apb_rsp,

  output logic        push,
  output logic        pop,
  output fifo_data_t  push_data,

  input  logic        empty,
  input  logic        full,
  input  fifo_count_t count,
  input  fifo_data_t  head
);

  acc_state_t state;

  logic       pready_q;
  logic       pslverr_q;
  apb_data_t  prdata_q;

  // second access cycle is next, so decode now
  logic       access_cycle;

  logic       is_data;
  logic       is_status;
  logic       do_push;
  logic       do_pop;
  logic       err;
  apb_data_t  rd_word;

  assign access_cycle = (state == WAIT) && apb_req.psel && apb_req.penable;

  // ----------------------------------------
  // address and direction decode
  // ----------------------------------------

  always_comb
  begin
    is_data   = (apb_req.paddr == REG_DATA);
    is_status = (apb_req.paddr == REG_STATUS);
    do_push   = 1'b0;
    do_pop    = 1'b0;
    err       = 1'b1;
    rd_word   = '0;

    if (is_data && apb_req.pwrite)
    begin
      // refused when full, nothing pushed
      if (!full)
      begin
        do_push = 1'b1;
        err     = 1'b0;
      end
    end
    else if (is_data && !apb_req.pwrite)
    begin
      // refused when empty, data stays zero
      if (!empty)
      begin
        do_pop  = 1'b1;
        err     = 1'b0;
        rd_word = apb_data_t'(head);
      end
    end
    else if (is_status && !apb_req.pwrite)
    begin
      err     = 1'b0;
      rd_word = apb_data_t'({count, 2'b00, full, empty});
    end
    // status writes and unmapped addresses keep err set
  end

  // ----------------------------------------
  // access FSM, one wait state
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
      push      <= 1'b0;
      pop       <= 1'b0;
    end
    else
    begin
      // strobes last a single cycle
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
      push      <= 1'b0;
      pop       <= 1'b0;

      case (state)
        IDLE:
          // setup phase seen
          if (apb_req.psel && !apb_req.penable)
            state <= WAIT;
        WAIT:
          if (access_cycle)
          begin
            state     <= DONE;
            pready_q  <= 1'b1;
            pslverr_q <= err;
            push      <= do_push;
            pop       <= do_pop;
          end
          else if (!apb_req.psel)
            state <= IDLE;
        DONE:
          state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  // response data and write nibble, captured with the decode
  always_ff @(posedge clk)
  begin
    if (access_cycle)
    begin
      prdata_q  <= rd_word;
      push_data <= fifo_data_t'(apb_req.pwdata[FIFO_WIDTH - 1:0]);
    end
  end

  assign apb_rsp = '{pready: pready_q, prdata: prdata_q, pslverr: pslverr_q};

endmodule

`default_nettype wire

/* compile.f */
fifo_pkg.sv
display_pkg.sv
apb_fifo_regs.sv
ff_fifo.sv
seg_display_scan.sv
fifo_display_top.sv
tb_fifo_display.sv

/* display_pkg.sv */
// Seven-segment display types, hex glyph table and scan rate for the multiplexed display
`default_nettype none

package display_pkg;

  // one digit per FIFO entry
  localparam int N_DIGITS = 8;

  // segments a..g then the dot in bit 0
  typedef logic [7:0]            seg_t;
  // one-hot digit enable, active high
  typedef logic [N_DIGITS - 1:0] digit_sel_t;
  typedef logic [2:0]            digit_idx_t;

  // hex digits 0..F in abcdefgh order
  localparam seg_t SEG_HEX [16] = '{
    8'hfc, 8'h60, 8'hda, 8'hf2,
    8'h66, 8'hb6, 8'hbe, 8'he0,
    8'hfe, 8'hf6, 8'hee, 8'h3e,
    8'h9c, 8'h7a, 8'h9e, 8'h8e
  };

  // middle segment only, marks an unused entry
  localparam seg_t SEG_EMPTY = 8'b0000_0010;

  // decimal point bit
  localparam seg_t SEG_DOT   = 8'b0000_0001;

  // clock cycles each digit stays selected
  localparam int SCAN_DIV = 4;

endpackage

`default_nettype wire

/* ff_fifo.sv */
// Flip-flop FIFO with empty and full flags, occupancy count and a debug view for the display
`timescale 1ns/1ps
`default_nettype none

module ff_fifo
  import fifo_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  input  logic        push,
  input  logic        pop,
  input  fifo_data_t  push_data,

  output logic        empty,
  output logic        full,
  output fifo_count_t count,
  output fifo_data_t  head,

  output fifo_view_t  view
);

  // ----------------------------------------
  // storage and pointers
  // ----------------------------------------

  fifo_data_t [FIFO_DEPTH - 1:0] mem;
  logic       [FIFO_DEPTH - 1:0] valid;

  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;

  // flips each time a pointer passes the last entry
  logic      wr_wrap;
  logic      rd_wrap;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      wr_wrap <= 1'b0;
      rd_wrap <= 1'b0;
      valid   <= '0;
    end
    else
    begin
      // requests are already checked against the flags upstream
      if (push)
      begin
        {wr_wrap, wr_ptr} <= {wr_wrap, wr_ptr} + (PTR_W + 1)'(1);
        valid[wr_ptr]     <= 1'b1;
      end

      if (pop)
      begin
        {rd_wrap, rd_ptr} <= {rd_wrap, rd_ptr} + (PTR_W + 1)'(1);
        valid[rd_ptr]     <= 1'b0;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  // ----------------------------------------
  // flags and count
  // ----------------------------------------

  // same position, wrap bits tell empty from full
  assign empty = (wr_ptr == rd_ptr) && (wr_wrap == rd_wrap);
  assign full  = (wr_ptr == rd_ptr) && (wr_wrap != rd_wrap);

  // modulo difference of the extended pointers
  assign count = fifo_count_t'({wr_wrap, wr_ptr} - {rd_wrap, rd_ptr});

  // oldest entry, valid whenever not empty
  assign head  = mem[rd_ptr];

  // debug export for the display
  assign view  = '{valid: valid, data: mem, wr_ptr: wr_ptr, rd_ptr: rd_ptr};

endmodule

`default_nettype wire

/* fifo_display_top.sv */
// Top level of the demonstrator, APB port into the FIFO and out to the seven-segment display
`timescale 1ns/1ps
`default_nettype none

module fifo_display_top
  import fifo_pkg::*;
  import display_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  apb_req_t   apb_req,
  output apb_rsp_t   apb_rsp,

  output seg_t       abcdefgh,
  output digit_sel_t digit
);

  // ----------------------------------------
  // register side to FIFO
  // ----------------------------------------

  logic        push;
  logic        pop;
  fifo_data_t  push_data;

  logic        empty;
  logic        full;
  fifo_count_t count;
  fifo_data_t  head;

  // FIFO internals for the display
  fifo_view_t  view;

  apb_fifo_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .push      (push),
    .pop       (pop),
    .push_data (push_data),
    .empty     (empty),
    .full      (full),
    .count     (count),
    .head      (head)
  );

  ff_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .pop       (pop),
    .push_data (push_data),
    .empty     (empty),
    .full      (full),
    .count     (count),
    .head      (head),
    .view      (view)
  );

  // scanned display, digit count matches FIFO depth
  seg_display_scan u_display (
    .clk       (clk),
    .rst_n     (rst_n),
    .view      (view),
    .abcdefgh  (abcdefgh),
    .digit     (digit)
  );

endmodule

`default_nettype wire

/* fifo_pkg.sv */
// FIFO geometry, APB register map and bus structs shared by the RTL and the testbench
`default_nettype none

package fifo_pkg;

  // ----------------------------------------
  // FIFO geometry
  // ----------------------------------------

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_WIDTH = 4;
  localparam int PTR_W      = 3;

  typedef logic [FIFO_WIDTH - 1:0] fifo_data_t;
  typedef logic [PTR_W      - 1:0] fifo_ptr_t;
  // occupancy 0..8 needs one bit more than a pointer
  typedef logic [PTR_W         :0] fifo_count_t;

  // ----------------------------------------
  // APB bus and register map
  // ----------------------------------------

  typedef logic [ 7:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // write pushes low nibble, read pops the head
  localparam apb_addr_t REG_DATA   = 8'h00;
  // bit 0 empty, bit 1 full, bits 7:4 count
  localparam apb_addr_t REG_STATUS = 8'h04;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic      pready;
    apb_data_t prdata;
    logic      pslverr;
  } apb_rsp_t;

  // debug view of the FIFO internals, used by the display
  typedef struct packed {
    logic       [FIFO_DEPTH - 1:0] valid;
    fifo_data_t [FIFO_DEPTH - 1:0] data;
    fifo_ptr_t                     wr_ptr;
    fifo_ptr_t                     rd_ptr;
  } fifo_view_t;

  // access phase tracking of the register slave
  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    DONE
  } acc_state_t;

endpackage

`default_nettype wire

/* seg_display_scan.sv */
// Eight-digit seven-segment scanner that shows the FIFO entries mirrored with pointer dots
`timescale 1ns/1ps
`default_nettype none

module seg_display_scan
  import fifo_pkg::*;
  import display_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  fifo_view_t view,

  output seg_t       abcdefgh,
  output digit_sel_t digit
);

  // ----------------------------------------
  // digit scan
  // ----------------------------------------

  logic [$clog2(SCAN_DIV) - 1:0] div_cnt;
  digit_idx_t                    scan_idx;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      div_cnt  <= '0;
      scan_idx <= '0;
    end
    else if (div_cnt == ($clog2(SCAN_DIV))'(SCAN_DIV - 1))
    begin
      // move on to the next digit, wraps after the last
      div_cnt  <= '0;
      scan_idx <= scan_idx + digit_idx_t'(1);
    end
    else
    begin
      div_cnt  <= div_cnt + ($clog2(SCAN_DIV))'(1);
    end
  end

  // one-hot select, digit 0 right after reset
  assign digit = digit_sel_t'(1) << scan_idx;

  // ----------------------------------------
  // segment encode
  // ----------------------------------------

  // digit i shows entry depth-1-i
  fifo_ptr_t  ent_idx;
  fifo_data_t ent_data;
  logic       ent_valid;
  logic       dot_on;

  assign ent_idx   = fifo_ptr_t'(FIFO_DEPTH - 1) - fifo_ptr_t'(scan_idx);
  assign ent_data  = view.data[ent_idx];
  assign ent_valid = view.valid[ent_idx];

  // dots follow the digit index, not the mirrored entry
  assign dot_on    = (fifo_ptr_t'(scan_idx) == view.wr_ptr)
                  || (fifo_ptr_t'(scan_idx) == view.rd_ptr);

  always_comb
  begin
    if (ent_valid)
    begin
      abcdefgh = SEG_HEX[ent_data];
      if (dot_on)
        abcdefgh = abcdefgh | SEG_DOT;
    end
    else
    begin
      // unused entry, dash without dot
      abcdefgh = SEG_EMPTY;
    end
  end

endmodule

`default_nettype wire

/* tb_fifo_display.sv */
// Table-driven testbench for the APB FIFO display top, run with the file list and the Makefile
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_display
  import fifo_pkg::*;
  import display_pkg::*;
();

  // ----------------------------------------
  // timing and limits
  // ----------------------------------------

  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DLY    = 1;
  // cycles allowed from access phase to pready
  localparam int PREADY_LIMIT = 8;

  typedef enum {OP_PUSH, OP_POP, OP_STATUS, OP_BAD, OP_DISPLAY} op_t;

  // one table row, expected values filled in by the queue model
  typedef struct {
    string      name;
    op_t        op;
    apb_addr_t  addr;
    logic       wr;
    apb_data_t  data;
    apb_data_t  exp_rdata;
    logic       exp_err;
    fifo_view_t snap;
  } step_t;

  logic       clk = 1'b0;
  logic       rst_n;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  seg_t       abcdefgh;
  digit_sel_t digit;

  step_t      steps[$];
  int         wd_cycles = 0;

  // reference model, queue for order plus slot view for the display
  fifo_data_t model_q[$];
  fifo_view_t model_view;

  always #2 clk = ~clk;

  fifo_display_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .abcdefgh (abcdefgh),
    .digit    (digit)
  );

  // ----------------------------------------
  // failure reporting and compares
  // ----------------------------------------

  task automatic fail_run();
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rsp(input string name, input apb_data_t exp_data, input logic exp_err,
                           input apb_data_t act_data, input logic act_err);
    if (act_data !== exp_data || act_err !== exp_err)
    begin
      $display("MISMATCH %s: expected prdata=%h pslverr=%b, actual prdata=%h pslverr=%b",
               name, exp_data, exp_err, act_data, act_err);
      fail_run();
    end
  endtask

  task automatic check_seg(input string name, input seg_t exp_seg, input seg_t act_seg);
    if (act_seg !== exp_seg)
    begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp_seg, act_seg);
      fail_run();
    end
  endtask

  // ----------------------------------------
  // table construction with the model
  // ----------------------------------------

  task automatic add_step(input string name, input op_t op, input apb_addr_t addr,
                          input logic wr, input apb_data_t data);
    step_t s;
    int    cnt;
    s.name      = name;
    s.op        = op;
    s.addr      = addr;
    s.wr        = wr;
    s.data      = data;
    s.exp_rdata = '0;
    s.exp_err   = 1'b0;
    cnt         = model_q.size();
    case (op)
      OP_PUSH:
        if (cnt == FIFO_DEPTH)
          s.exp_err = 1'b1;
        else
        begin
          // only the low nibble is stored
          model_q.push_back(data[FIFO_WIDTH - 1:0]);
          model_view.data[model_view.wr_ptr]  = data[FIFO_WIDTH - 1:0];
          model_view.valid[model_view.wr_ptr] = 1'b1;
          model_view.wr_ptr = model_view.wr_ptr + fifo_ptr_t'(1);
        end
      OP_POP:
        if (cnt == 0)
          s.exp_err = 1'b1;
        else
        begin
          s.exp_rdata = apb_data_t'(model_q.pop_front());
          model_view.valid[model_view.rd_ptr] = 1'b0;
          model_view.rd_ptr = model_view.rd_ptr + fifo_ptr_t'(1);
        end
      OP_STATUS:
      begin
        // bit 0 empty, bit 1 full, bits 7:4 count
        s.exp_rdata[7:4] = fifo_count_t'(cnt);
        s.exp_rdata[1]   = (cnt == FIFO_DEPTH);
        s.exp_rdata[0]   = (cnt == 0);
      end
      OP_BAD:
        s.exp_err = 1'b1;
      default:
        s.exp_err = 1'b0;
    endcase
    s.snap = model_view;
    steps.push_back(s);
  endtask

  task automatic build_table();
    int k;
    int n_disp;
    model_q.delete();
    model_view = '0;
    add_step("reset status", OP_STATUS, REG_STATUS, 1'b0, '0);
    add_step("reset display", OP_DISPLAY, REG_DATA, 1'b0, '0);
    // random values come back in push order
    for (k = 0; k < 3; k++)
    begin
      add_step($sformatf("order push %0d", k), OP_PUSH, REG_DATA, 1'b1, $urandom());
      add_step($sformatf("order push status %0d", k), OP_STATUS, REG_STATUS, 1'b0, '0);
    end
    for (k = 0; k < 3; k++)
    begin
      add_step($sformatf("order pop %0d", k), OP_POP, REG_DATA, 1'b0, '0);
      add_step($sformatf("order pop status %0d", k), OP_STATUS, REG_STATUS, 1'b0, '0);
    end
    // fill to full, then one push too many
    for (k = 0; k < FIFO_DEPTH; k++)
      add_step($sformatf("fill push %0d", k), OP_PUSH, REG_DATA, 1'b1, $urandom());
    add_step("full status", OP_STATUS, REG_STATUS, 1'b0, '0);
    add_step("overflow push", OP_PUSH, REG_DATA, 1'b1, $urandom());
    add_step("overflow status", OP_STATUS, REG_STATUS, 1'b0, '0);
    // drain, then one pop too many
    for (k = 0; k < FIFO_DEPTH; k++)
      add_step($sformatf("drain pop %0d", k), OP_POP, REG_DATA, 1'b0, '0);
    add_step("underflow pop", OP_POP, REG_DATA, 1'b0, '0);
    add_step("underflow status", OP_STATUS, REG_STATUS, 1'b0, '0);
    // refused accesses leave the FIFO alone
    add_step("unmapped read", OP_BAD, 8'h08, 1'b0, '0);
    add_step("unmapped write", OP_BAD, 8'h0c, 1'b1, $urandom());
    add_step("status write", OP_BAD, REG_STATUS, 1'b1, $urandom());
    add_step("refused status", OP_STATUS, REG_STATUS, 1'b0, '0);
    // partial fill that wraps the write pointer past the last entry
    for (k = 0; k < 7; k++)
      add_step($sformatf("wrap push %0d", k), OP_PUSH, REG_DATA, 1'b1, $urandom());
    for (k = 0; k < 3; k++)
      add_step($sformatf("wrap pop %0d", k), OP_POP, REG_DATA, 1'b0, '0);
    // refill so both pointer dots land on valid digits
    for (k = 0; k < 2; k++)
      add_step($sformatf("refill push %0d", k), OP_PUSH, REG_DATA, 1'b1, $urandom());
    add_step("wrap status", OP_STATUS, REG_STATUS, 1'b0, '0);
    add_step("wrap display", OP_DISPLAY, REG_DATA, 1'b0, '0);
    n_disp = 0;
    foreach (steps[i])
      if (steps[i].op == OP_DISPLAY)
        n_disp++;
    wd_cycles = RESET_CYCLES + steps.size() * 20 + n_disp * 8 * N_DIGITS * SCAN_DIV;
  endtask

  // ----------------------------------------
  // bus and display drivers
  // ----------------------------------------

  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic slverr);
    int waited;
    waited          = 0;
    // setup phase
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #DRIVE_DLY;
    apb_req.penable = 1'b1;
    // first access cycle is the wait state
    if (apb_rsp.pready !== 1'b0)
    begin
      $display("pready was not low in the first access cycle");
      fail_run();
    end
    // access phase until the slave answers
    do
    begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
      if (waited > PREADY_LIMIT)
      begin
        $display("no pready from the DUT within %0d cycles", PREADY_LIMIT);
        fail_run();
      end
    end
    while (apb_rsp.pready !== 1'b1);
    if (waited != 1)
    begin
      $display("pready came in access cycle %0d instead of the second", waited + 1);
      fail_run();
    end
    rdata           = apb_rsp.prdata;
    slverr          = apb_rsp.pslverr;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    // slave goes back to idle before the next setup
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic check_display(input step_t s);
    int         i;
    int         waited;
    digit_sel_t sel;
    fifo_ptr_t  ent;
    seg_t       exp_seg;
    for (i = 0; i < N_DIGITS; i++)
    begin
      sel    = digit_sel_t'(1) << i;
      waited = 0;
      while (digit !== sel)
      begin
        @(posedge clk);
        #DRIVE_DLY;
        waited++;
        if (waited > 2 * N_DIGITS * SCAN_DIV)
        begin
          $display("digit %0d was never selected by the scanner", i);
          fail_run();
        end
      end
      // digit i shows the mirrored entry
      ent = fifo_ptr_t'(FIFO_DEPTH - 1 - i);
      if (s.snap.valid[ent])
      begin
        exp_seg = SEG_HEX[s.snap.data[ent]];
        if (fifo_ptr_t'(i) == s.snap.wr_ptr || fifo_ptr_t'(i) == s.snap.rd_ptr)
          exp_seg = exp_seg | SEG_DOT;
      end
      else
        exp_seg = SEG_EMPTY;
      check_seg($sformatf("%s digit %0d", s.name, i), exp_seg, abcdefgh);
    end
  endtask

  task automatic run_step(input step_t s);
    apb_data_t rdata;
    logic      slverr;
    if (s.op == OP_DISPLAY)
      check_display(s);
    else
    begin
      apb_xfer(s.wr, s.addr, s.data, rdata, slverr);
      check_rsp(s.name, s.exp_rdata, s.exp_err, rdata, slverr);
    end
  endtask

  // ----------------------------------------
  // main sequence and watchdog
  // ----------------------------------------

  initial
  begin
    rst_n   = 1'b0;
    apb_req = '0;
    void'($urandom(63));
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    foreach (steps[k])
      run_step(steps[k]);
    $display("Everything OK");
    $finish;
  end

  initial
  begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk);
    $display("timeout, the run took longer than %0d cycles", wd_cycles);
    fail_run();
  end

endmodule

`default_nettype wire
